/* axil_sram.f */
rtl/axil_sram_pkg.sv
rtl/axil_sram_wr_front.sv
rtl/axil_sram_cmd_fifo.sv
rtl/axil_sram_store.sv
rtl/axil_sram_top.sv
dv/axil_sram_tb_clk.sv
dv/axil_sram_tb.sv

/* dv/axil_sram_tb.sv */
`timescale 1ns/1ps

module axil_sram_tb;
  import axil_sram_pkg::*;

  logic       clk;
  logic       rst_n;
  axil_addr_t awaddr;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic       wvalid;
  logic       wready;
  axil_resp_t bresp;
  logic       bvalid;
  logic       bready;
  logic       rd_en;
  axil_addr_t rd_addr;
  axil_data_t rd_data;

  logic [31:0] lfsr_state;
  axil_data_t  ref_mem [2**MEM_INDEX_WIDTH];
  axil_strb_t  ref_known [2**MEM_INDEX_WIDTH];
  int          checks;
  int          errors;
  int          tests;

  axil_sram_tb_clk axil_sram_tb_clk_i (.clk(clk), .rst_n(rst_n));

  axil_sram_top axil_sram_top_i (.*);

  // ==========================================================
  // Checks, LFSR and reference memory
  // ==========================================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR t=%0t %s", $time, what);
    end
  endtask

  function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  // Word address drops the byte-lane bit and aliases on its low bits
  function automatic logic [MEM_INDEX_WIDTH-1:0] ref_index(input axil_addr_t addr);
    axil_addr_t word;
    word = addr >> 1;
    return word[MEM_INDEX_WIDTH-1:0];
  endfunction

  function automatic void ref_write(input axil_addr_t addr, input axil_data_t data,
                                    input axil_strb_t strb);
    logic [MEM_INDEX_WIDTH-1:0] idx;
    idx = ref_index(addr);
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (strb[i]) begin
        ref_mem[idx][i*8 +: 8] = data[i*8 +: 8];
        ref_known[idx][i] = 1'b1;
      end
    end
  endfunction

  // ==========================================================
  // Bus tasks
  // ==========================================================
  // Positive lead puts AW that many cycles ahead of W, negative puts W first
  task automatic offer_aw_w(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int lead,
                            input int max_cycles, output logic ok);
    int   cyc;
    int   aw_at;
    int   w_at;
    logic aw_hs;
    logic w_hs;
    logic aw_done;
    logic w_done;
    aw_at = (lead < 0) ? -lead : 0;
    w_at = (lead > 0) ? lead : 0;
    {aw_hs, w_hs, aw_done, w_done} = '0;
    cyc = 0;
    while (!(aw_done && w_done) && (aw_hs || w_hs || cyc < max_cycles)) begin
      @(posedge clk);
      if (aw_hs) begin
        awvalid <= 1'b0;
        aw_done = 1'b1;
      end else if (!aw_done && cyc == aw_at) begin
        awvalid <= 1'b1;
        awaddr <= addr;
      end
      if (w_hs) begin
        wvalid <= 1'b0;
        w_done = 1'b1;
      end else if (!w_done && cyc == w_at) begin
        wvalid <= 1'b1;
        wdata <= data;
        wstrb <= strb;
      end
      @(negedge clk);
      aw_hs = !aw_done && awvalid && awready;
      w_hs = !w_done && wvalid && wready;
      cyc++;
    end
    ok = aw_done && w_done;
    if (!ok) begin
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid <= 1'b0;
    end
  endtask

  task automatic take_b(input int delay, input int max_cycles, output logic got);
    int   cyc;
    logic hs;
    hs = 1'b0;
    got = 1'b0;
    cyc = 0;
    while (!got && (hs || cyc < max_cycles)) begin
      @(posedge clk);
      if (hs) begin
        bready <= 1'b0;
        got = 1'b1;
      end else if (cyc == delay) begin
        bready <= 1'b1;
      end
      @(negedge clk);
      // One response per write, so bvalid must be gone after the handshake
      if (got) begin
        check_value("bvalid", 32'(bvalid), 32'h0);
      end else begin
        hs = bvalid && bready;
      end
      if (hs && !got) begin
        check_value("bresp", 32'(bresp), 32'h0);
      end
      cyc++;
    end
    if (!got) begin
      @(posedge clk);
      bready <= 1'b0;
    end
  endtask

  task automatic write_word(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int lead, input int delay);
    logic ok;
    offer_aw_w(addr, data, strb, lead, 50, ok);
    check_flag(ok, "AW or W handshake timed out");
    take_b(delay, 50, ok);
    check_flag(ok, "no B response before timeout");
    ref_write(addr, data, strb);
  endtask

  task automatic read_word(input axil_addr_t addr, output axil_data_t data);
    @(posedge clk);
    rd_en <= 1'b1;
    rd_addr <= addr;
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);
    data = rd_data;
  endtask

  // Only bytes that some write has set are compared
  task automatic check_readback(input axil_addr_t addr);
    logic [MEM_INDEX_WIDTH-1:0] idx;
    axil_data_t                 mask;
    axil_data_t                 got;
    idx = ref_index(addr);
    mask = {{8{ref_known[idx][1]}}, {8{ref_known[idx][0]}}};
    read_word(addr, got);
    check_value("rd_data", 32'(got & mask), 32'(ref_mem[idx] & mask));
  endtask

  task automatic drain_fifo();
    for (int i = 0; i < CMD_FIFO_DEPTH + 2; i++) begin
      @(posedge clk);
      rd_en <= 1'b0;
    end
  endtask

  task automatic wait_reset();
    int cyc;
    cyc = 0;
    do begin
      @(posedge clk);
      cyc++;
    end while (rst_n !== 1'b1 && cyc < 50);
    check_flag(rst_n === 1'b1, "reset was never released");
  endtask

  task automatic end_test(input string name, input int err_start);
    tests++;
    $display("test %-14s %0d errors", name, errors - err_start);
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================
  task automatic test_reset_state();
    int err_start;
    err_start = errors;
    @(negedge clk);
    check_value("awready", 32'(awready), 32'h1);
    check_value("wready", 32'(wready), 32'h1);
    check_value("bvalid", 32'(bvalid), 32'h0);
    end_test("reset_state", err_start);
  endtask

  task automatic test_channel_order();
    int err_start;
    err_start = errors;
    write_word(20'h0_0020, 16'hbeef, 2'b11, 2, 1);
    write_word(20'h0_0032, 16'h5a17, 2'b11, -2, 0);
    drain_fifo();
    check_readback(20'h0_0020);
    check_readback(20'h0_0032);
    end_test("channel_order", err_start);
  endtask

  task automatic test_byte_strobes();
    int         err_start;
    axil_data_t got;
    err_start = errors;
    write_word(20'h0_0104, 16'hffff, 2'b11, 0, 0);
    write_word(20'h0_0104, 16'h12ab, 2'b01, 1, 0);
    drain_fifo();
    read_word(20'h0_0104, got);
    check_value("rd_data", 32'(got), 32'h0000_ffab);
    end_test("byte_strobes", err_start);
  endtask

  task automatic test_back_pressure();
    int         err_start;
    int         b_count;
    logic       ok;
    axil_addr_t addr [6];
    axil_data_t data [6];
    err_start = errors;
    b_count = 0;
    for (int i = 0; i < 6; i++) begin
      addr[i] = axil_addr_t'(32'h0_0300 + 6 * i);
      data[i] = axil_data_t'(32'h7100 + 32'h0111 * i);
      ref_write(addr[i], data[i], 2'b11);
    end
    @(posedge clk);
    rd_en <= 1'b1;
    rd_addr <= '0;
    // Fifth write waits in the holding registers while rd_en is high
    for (int i = 0; i < 5; i++) begin
      offer_aw_w(addr[i], data[i], 2'b11, 0, 20, ok);
      check_flag(ok, "write not accepted while read traffic was on");
      take_b(0, 12, ok);
      if (ok) begin
        b_count++;
      end
    end
    check_value("b_count", 32'(b_count), 32'(CMD_FIFO_DEPTH));
    offer_aw_w(addr[5], data[5], 2'b11, 0, 8, ok);
    check_flag(!ok, "sixth write accepted with no credits left");
    @(negedge clk);
    check_flag(!awready || !wready, "front end ready while out of credits");
    @(posedge clk);
    rd_en <= 1'b0;
    take_b(0, 20, ok);
    if (ok) begin
      b_count++;
    end
    offer_aw_w(addr[5], data[5], 2'b11, 0, 20, ok);
    check_flag(ok, "held-back write not accepted after read traffic stopped");
    take_b(0, 20, ok);
    if (ok) begin
      b_count++;
    end
    check_value("b_count", 32'(b_count), 32'h6);
    drain_fifo();
    for (int i = 0; i < 6; i++) begin
      check_readback(addr[i]);
    end
    end_test("back_pressure", err_start);
  endtask

  task automatic test_random();
    int          err_start;
    logic [10:0] upper;
    logic [7:0]  idx;
    axil_addr_t  addr;
    axil_data_t  data;
    axil_strb_t  strb;
    int          lead;
    int          delay;
    err_start = errors;
    for (int i = 0; i < 40; i++) begin
      upper = 11'(take_bits(11));
      // Eight indices under random upper bits, so aliasing is certain
      idx = 8'h40 + 8'(take_bits(3));
      addr = {upper, idx, take_bit()};
      data = 16'(take_bits(16));
      strb = 2'(take_bits(2));
      lead = int'(take_bits(2)) - 1;
      delay = int'(take_bits(2));
      write_word(addr, data, strb, lead, delay);
    end
    drain_fifo();
    for (int j = 0; j < 2**MEM_INDEX_WIDTH; j++) begin
      if (ref_known[j] != '0) begin
        check_readback({11'h2a5, 8'(j), 1'b0});
      end
    end
    end_test("random", err_start);
  endtask

  initial begin
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    rd_en = 1'b0;
    rd_addr = '0;
    lfsr_state = 32'he834_5e51;
    checks = 0;
    errors = 0;
    tests = 0;
    for (int i = 0; i < 2**MEM_INDEX_WIDTH; i++) begin
      ref_known[i] = '0;
    end

    wait_reset();
    test_reset_state();
    test_channel_order();
    test_byte_strobes();
    test_back_pressure();
    test_random();

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* dv/axil_sram_tb_clk.sv */
`timescale 1ns/1ps

module axil_sram_tb_clk (
  output logic clk,
  output logic rst_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Held low for the first 5 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* rtl/axil_sram_cmd_fifo.sv */
`timescale 1ns/1ps

module axil_sram_cmd_fifo (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  push,
  input  axil_sram_pkg::wr_cmd_t push_cmd,

  input  logic                  pop,
  output axil_sram_pkg::wr_cmd_t head_cmd,
  output logic                  not_empty,
  output logic                  credit_return
);
  import axil_sram_pkg::*;

  wr_cmd_t                            mem [CMD_FIFO_DEPTH];
  logic [$clog2(CMD_FIFO_DEPTH)-1:0]  wr_ptr;
  logic [$clog2(CMD_FIFO_DEPTH)-1:0]  rd_ptr;
  fifo_count_t                        count;
  logic                               do_pop;

  assign not_empty = (count != '0);
  assign head_cmd  = mem[rd_ptr];
  assign do_pop    = pop && not_empty;

  // One credit back to the front end per entry leaving
  assign credit_return = do_pop;

  // ==========================================================
  // Pointers and occupancy
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

endmodule

/* rtl/axil_sram_pkg.sv */
package axil_sram_pkg;

  // ==========================================================
  // AXI-Lite port widths
  // ==========================================================
  localparam int AXIL_ADDR_WIDTH = 20;
  localparam int AXIL_DATA_WIDTH = 16;
  localparam int STRB_WIDTH = AXIL_DATA_WIDTH / 8;
  // Byte address minus the byte-lane bit
  localparam int WORD_ADDR_WIDTH = AXIL_ADDR_WIDTH - $clog2(STRB_WIDTH);

  // 256-word SRAM indexed by the low word address bits
  localparam int MEM_INDEX_WIDTH = 8;

  // Credits after reset equal the FIFO depth
  localparam int CMD_FIFO_DEPTH = 4;
  localparam int CREDIT_WIDTH = 3;

  typedef logic [AXIL_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_WIDTH-1:0] axil_data_t;
  typedef logic [STRB_WIDTH-1:0] axil_strb_t;
  typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [1:0] axil_resp_t;
  typedef logic [CREDIT_WIDTH-1:0] fifo_count_t;

  localparam axil_resp_t RESP_OKAY = 2'b00;

  typedef struct packed {
    word_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
  } wr_cmd_t;

endpackage

/* rtl/axil_sram_store.sv */
`timescale 1ns/1ps

module axil_sram_store (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     rd_en,
  input  axil_sram_pkg::axil_addr_t rd_addr,
  output axil_sram_pkg::axil_data_t rd_data,

  input  logic                     not_empty,
  input  axil_sram_pkg::wr_cmd_t    head_cmd,
  output logic                     pop
);
  import axil_sram_pkg::*;

  axil_data_t                 mem [2**MEM_INDEX_WIDTH];
  word_addr_t                 rd_word;
  logic [MEM_INDEX_WIDTH-1:0] rd_idx;
  logic [MEM_INDEX_WIDTH-1:0] wr_idx;

  // Higher word addresses alias onto the low index bits
  assign rd_word = rd_addr[AXIL_ADDR_WIDTH-1:AXIL_ADDR_WIDTH-WORD_ADDR_WIDTH];
  assign rd_idx  = rd_word[MEM_INDEX_WIDTH-1:0];
  assign wr_idx  = head_cmd.addr[MEM_INDEX_WIDTH-1:0];

  // ==========================================================
  // Port arbitration
  // ==========================================================
  // Debug read owns the single port when requested
  assign pop = not_empty && !rd_en;

  always_ff @(posedge clk) begin
    if (pop) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (head_cmd.strb[i]) begin
          mem[wr_idx][i*8 +: 8] <= head_cmd.data[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_idx];
    end
  end

endmodule

/* rtl/axil_sram_top.sv */
`timescale 1ns/1ps

module axil_sram_top (
  input  logic                     clk,
  input  logic                     rst_n,

  // AXI-Lite write channels
  input  axil_sram_pkg::axil_addr_t awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  axil_sram_pkg::axil_data_t wdata,
  input  axil_sram_pkg::axil_strb_t wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output axil_sram_pkg::axil_resp_t bresp,
  output logic                     bvalid,
  input  logic                     bready,

  // Debug read port
  input  logic                     rd_en,
  input  axil_sram_pkg::axil_addr_t rd_addr,
  output axil_sram_pkg::axil_data_t rd_data
);
  import axil_sram_pkg::*;

  logic    push;
  wr_cmd_t push_cmd;
  logic    credit_return;
  logic    pop;
  logic    not_empty;
  wr_cmd_t head_cmd;

  // ==========================================================
  // Front end, command FIFO, SRAM
  // ==========================================================
  axil_sram_wr_front axil_sram_wr_front_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .push         (push),
    .push_cmd     (push_cmd),
    .credit_return(credit_return)
  );

  axil_sram_cmd_fifo axil_sram_cmd_fifo_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_cmd     (push_cmd),
    .pop          (pop),
    .head_cmd     (head_cmd),
    .not_empty    (not_empty),
    .credit_return(credit_return)
  );

  axil_sram_store axil_sram_store_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .not_empty(not_empty),
    .head_cmd (head_cmd),
    .pop      (pop)
  );

endmodule

/* rtl/axil_sram_wr_front.sv */
`timescale 1ns/1ps

module axil_sram_wr_front (
  input  logic                     clk,
  input  logic                     rst_n,

  input  axil_sram_pkg::axil_addr_t awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  axil_sram_pkg::axil_data_t wdata,
  input  axil_sram_pkg::axil_strb_t wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output axil_sram_pkg::axil_resp_t bresp,
  output logic                     bvalid,
  input  logic                     bready,

  output logic                     push,
  output axil_sram_pkg::wr_cmd_t    push_cmd,
  input  logic                     credit_return
);
  import axil_sram_pkg::*;

  logic        aw_full;
  logic        w_full;
  word_addr_t  aw_addr;
  axil_data_t  w_data;
  axil_strb_t  w_strb;
  fifo_count_t credits;

  // ==========================================================
  // AW and W holding registers
  // ==========================================================
  // No new beats while a B response is outstanding
  assign awready = !aw_full && !bvalid;
  assign wready  = !w_full && !bvalid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        aw_full <= 1'b1;
      end else if (push) begin
        aw_full <= 1'b0;
      end

      if (wvalid && wready) begin
        w_full <= 1'b1;
      end else if (push) begin
        w_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      aw_addr <= awaddr[AXIL_ADDR_WIDTH-1:AXIL_ADDR_WIDTH-WORD_ADDR_WIDTH];
    end
    if (wvalid && wready) begin
      w_data <= wdata;
      w_strb <= wstrb;
    end
  end

  // ==========================================================
  // Command push and credits
  // ==========================================================
  assign push     = aw_full && w_full && (credits != '0);
  assign push_cmd = '{addr: aw_addr, data: w_data, strb: w_strb};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= fifo_count_t'(CMD_FIFO_DEPTH);
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // B goes out once the command is queued
  assign bresp = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
    end else if (push) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the AXI-Lite SRAM testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module axil_sram_tb \
  -f axil_sram.f \
  --Mdir "$OBJ_DIR" -o axil_sram_sim
if [ $? -ne 0 ]; then
  echo "run.sh: Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/axil_sram_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "run.sh: simulation exited with status $sim_status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
exit 0
